/* build.f */
mem_mon_pkg.sv
avmm_event_capture.sv
traffic_counters.sv
wr_burst_tracker.sv
csr_readout.sv
mem_traffic_monitor.sv
tb_mem_traffic_monitor.sv

/* tb_mem_traffic_monitor.sv */
// Testbench of the memory traffic monitor
// Random channel traffic, host write bursts, counter clear and register port checks
`default_nettype none

module tb_mem_traffic_monitor
  import mem_mon_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic                                host_mem_if;
  logic                                reset;
  logic [num_channels-1:0]             mon_read;
  logic [num_channels-1:0]             mon_write;
  logic [num_channels-1:0]             mon_waitrequest;
  logic [num_channels-1:0]             mon_readdatavalid;
  logic [num_channels*burst_width-1:0] mon_burstcount;
  logic                                host_wr_write;
  logic                                host_wr_waitrequest;
  logic [burst_width-1:0]              host_wr_burstcount;
  logic                                csr_read;
  logic                                csr_write;
  logic [csr_addr_width-1:0]           csr_address;
  logic [csr_data_width-1:0]           csr_readdata;
  logic                                csr_readdatavalid;

  integer                 seed = 32'h8792f25c;
  int                     errors = 0;
  int                     checks = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  // Expected counts in the channel major order of the register window
  logic [count_width-1:0] ref_cnt [num_counters];

  mem_traffic_monitor mem_traffic_monitor_inst (.*);

  initial
  begin
    host_mem_if = 1'b0;
    forever #5 host_mem_if = ~host_mem_if;
  end

  // Read data valid only ever follows a read strobe
  assert property (@(posedge host_mem_if) disable iff (reset)
    csr_readdatavalid |-> $past(csr_read))
  else
  begin
    $display("csr_readdatavalid rose without a csr_read in the cycle before");
    errors++;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic read_reg(input logic [csr_addr_width-1:0] addr, output logic [63:0] data);
    int waited;
    @(negedge host_mem_if);
    csr_read    = 1'b1;
    csr_address = addr;
    @(negedge host_mem_if);
    csr_read = 1'b0;
    waited   = 0;
    while (!csr_readdatavalid && waited < 20)
    begin
      @(negedge host_mem_if);
      waited++;
    end
    if (!csr_readdatavalid)
    begin
      $display("No read response from address 0x%0h within %0d cycles", addr, waited);
      $display("TESTS FAILED");
      $finish;
    end
    else
    begin
      data = csr_readdata;
    end
  endtask

  // Quiet inputs and let the counters settle
  task automatic go_idle();
    @(negedge host_mem_if);
    mon_read          = '0;
    mon_write         = '0;
    mon_readdatavalid = '0;
    mon_waitrequest   = '0;
    host_wr_write     = 1'b0;
    repeat (4) @(negedge host_mem_if);
  endtask

  task automatic drive_traffic(input int cycles, input bit reads, input bit others);
    logic [burst_width-1:0] bc;
    int                     base;
    for (int n = 0; n < cycles; n++)
    begin
      @(negedge host_mem_if);
      mon_read          = reads ? num_channels'($random(seed)) : '0;
      mon_write         = others ? num_channels'($random(seed)) : '0;
      mon_readdatavalid = others ? num_channels'($random(seed)) : '0;
      mon_waitrequest   = num_channels'($random(seed));
      for (int ch = 0; ch < num_channels; ch++)
      begin
        bc   = burst_width'($random(seed));
        base = ch * num_kinds;
        mon_burstcount[ch*burst_width +: burst_width] = bc;
        if (mon_read[ch] && !mon_waitrequest[ch])
        begin
          ref_cnt[base + int'(cnt_rd)]++;
          ref_cnt[base + int'(cnt_rdline)] += bc;
        end
        if (mon_write[ch] && !mon_waitrequest[ch])
          ref_cnt[base + int'(cnt_wr)]++;
        if (mon_readdatavalid[ch])
          ref_cnt[base + int'(cnt_rdresp)]++;
      end
    end
    go_idle();
  endtask

  task automatic check_counters();
    logic [63:0] data;
    for (int i = 0; i < num_counters; i++)
    begin
      read_reg(csr_addr_width'(i), data);
      check_value($sformatf("csr_readdata ch%0d kind%0d", i / num_kinds, i % num_kinds),
                  data, 64'(ref_cnt[i]));
    end
  endtask

  // Accepted beats of one host write burst under random stalls
  task automatic host_beats(input int beats, input logic [burst_width-1:0] burst);
    int taken;
    int waited;
    taken  = 0;
    waited = 0;
    while (taken < beats && waited < 100)
    begin
      @(negedge host_mem_if);
      host_wr_write       = 1'b1;
      host_wr_burstcount  = burst;
      host_wr_waitrequest = 1'($random(seed));
      if (!host_wr_waitrequest)
        taken++;
      waited++;
    end
    go_idle();
    if (taken < beats)
    begin
      $display("Host write port accepted only %0d of %0d beats", taken, beats);
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  initial
  begin
    logic [63:0] data;
    logic [63:0] first;
    int          mark;
    int          valid_seen;
    reset = 1'b1;
    {mon_read, mon_write, mon_waitrequest, mon_readdatavalid} = '0;
    mon_burstcount = '0;
    {host_wr_write, host_wr_waitrequest, csr_read, csr_write} = '0;
    host_wr_burstcount = '0;
    csr_address = '0;
    foreach (ref_cnt[i])
    begin
      ref_cnt[i] = '0;
    end
    repeat (5) @(negedge host_mem_if);
    reset = 1'b0;

    mark = errors;
    check_counters();
    read_reg(reg_burst_status, data);
    check_value("csr_readdata burst status", data, 64'h1_0000_0000);
    end_test("after reset", mark);

    mark = errors;
    drive_traffic(60, 1'b1, 1'b0);
    check_counters();
    end_test("random reads with stalls", mark);

    mark = errors;
    drive_traffic(60, 1'b0, 1'b1);
    check_counters();
    end_test("random responses and writes", mark);

    // Burst of 5 left open after 2 beats
    mark = errors;
    host_beats(2, 6'd5);
    read_reg(reg_burst_status, first);
    check_value("sop", first[32], 0);
    check_value("bursts_rem", first[21:16], 3);
    repeat (6) @(negedge host_mem_if);
    read_reg(reg_burst_status, data);
    check_value("open_cycles grew", data[13:0] > first[13:0], 1);
    host_beats(3, 6'd5);
    read_reg(reg_burst_status, data);
    check_value("csr_readdata burst status", data, 64'h1_0000_0000);
    end_test("open host write burst", mark);

    mark = errors;
    host_beats(1, 6'd3);
    @(negedge host_mem_if);
    csr_write   = 1'b1;
    csr_address = reg_clear;
    @(negedge host_mem_if);
    csr_write = 1'b0;
    foreach (ref_cnt[i])
    begin
      ref_cnt[i] = '0;
    end
    check_counters();
    drive_traffic(30, 1'b1, 1'b1);
    check_counters();
    read_reg(reg_burst_status, data);
    check_value("sop", data[32], 0);
    check_value("bursts_rem", data[21:16], 2);
    end_test("clear", mark);

    // Unmapped address read with its valid pulses counted
    mark = errors;
    @(negedge host_mem_if);
    csr_read    = 1'b1;
    csr_address = 8'h40;
    @(negedge host_mem_if);
    csr_read   = 1'b0;
    valid_seen = 0;
    repeat (4)
    begin
      if (csr_readdatavalid)
      begin
        valid_seen++;
        data = csr_readdata;
      end
      @(negedge host_mem_if);
    end
    check_value("csr_readdatavalid pulses", valid_seen, 1);
    check_value("csr_readdata unmapped", data, 0);
    end_test("register port behavior", mark);

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* mem_traffic_monitor.sv */
// Memory traffic monitor top with event capture, traffic counters,
// host write burst tracker and register readout
`default_nettype none

module mem_traffic_monitor
  import mem_mon_pkg::*;
(
  input  wire logic                                 host_mem_if,
  input  wire logic                                 reset,
  input  wire logic [num_channels-1:0]              mon_read,
  input  wire logic [num_channels-1:0]              mon_write,
  input  wire logic [num_channels-1:0]              mon_waitrequest,
  input  wire logic [num_channels-1:0]              mon_readdatavalid,
  input  wire logic [num_channels*burst_width-1:0]  mon_burstcount,
  input  wire logic                                 host_wr_write,
  input  wire logic                                 host_wr_waitrequest,
  input  wire logic [burst_width-1:0]               host_wr_burstcount,
  input  wire logic                                 csr_read,
  input  wire logic                                 csr_write,
  input  wire logic [csr_addr_width-1:0]            csr_address,
  output logic      [csr_data_width-1:0]            csr_readdata,
  output logic                                      csr_readdatavalid
);

  // Registered events
  logic [num_channels-1:0]             rd_accept;
  logic [num_channels*burst_width-1:0] rd_lines;
  logic [num_channels-1:0]             wr_accept;
  logic [num_channels-1:0]             rdresp;
  logic                                host_beat;
  logic [burst_width-1:0]              host_beat_burst;

  // Counter and tracker state
  logic [num_counters*count_width-1:0] count_flat;
  logic                                sop;
  logic [burst_width-1:0]              bursts_rem;
  logic [open_width-1:0]               open_cycles;
  logic                                clear;

  avmm_event_capture avmm_event_capture_inst (
    .host_mem_if, .reset,
    .mon_read, .mon_write, .mon_waitrequest, .mon_readdatavalid, .mon_burstcount,
    .host_wr_write, .host_wr_waitrequest, .host_wr_burstcount,
    .rd_accept, .rd_lines, .wr_accept, .rdresp, .host_beat, .host_beat_burst
  );

  traffic_counters traffic_counters_inst (
    .host_mem_if, .reset, .clear,
    .rd_accept, .rd_lines, .wr_accept, .rdresp,
    .count_flat
  );

  wr_burst_tracker wr_burst_tracker_inst (
    .host_mem_if, .reset, .host_beat, .host_beat_burst,
    .sop, .bursts_rem, .open_cycles
  );

  csr_readout csr_readout_inst (
    .host_mem_if, .reset, .csr_read, .csr_write, .csr_address,
    .count_flat, .sop, .bursts_rem, .open_cycles,
    .clear, .csr_readdata, .csr_readdatavalid
  );

endmodule

`default_nettype wire

/* csr_readout.sv */
// Register port decode of the counter window, burst status and clear command
// Read data returns one cycle after the read strobe
`default_nettype none

module csr_readout
  import mem_mon_pkg::*;
(
  input  wire logic                                host_mem_if,
  input  wire logic                                reset,
  input  wire logic                                csr_read,
  input  wire logic                                csr_write,
  input  wire logic [csr_addr_width-1:0]           csr_address,
  input  wire logic [num_counters*count_width-1:0] count_flat,
  input  wire logic                                sop,
  input  wire logic [burst_width-1:0]              bursts_rem,
  input  wire logic [open_width-1:0]               open_cycles,
  output logic                                     clear,
  output logic      [csr_data_width-1:0]           csr_readdata,
  output logic                                     csr_readdatavalid
);

  logic                        in_window;
  logic [count_sel_width-1:0]  sel;
  logic [csr_data_width-1:0]   status_word;
  logic [csr_data_width-1:0]   read_word;

  // Counter window 0 to 15 with channel in bits 3:2 and kind in bits 1:0
  assign in_window = (csr_address >> count_sel_width) == (reg_count_base >> count_sel_width);
  assign sel       = csr_address[count_sel_width-1:0];

  // Clear lasts the single cycle of the write strobe
  assign clear = csr_write && (csr_address == reg_clear);

  always_comb
  begin
    status_word                                  = '0;
    status_word[open_width-1:0]                  = open_cycles;
    status_word[status_rem_lsb +: burst_width]   = bursts_rem;
    status_word[status_sop_bit]                  = sop;
  end

  always_comb
  begin
    if (in_window)
    begin
      read_word = csr_data_width'(count_flat[sel*count_width +: count_width]);
    end
    else if (csr_address == reg_burst_status)
    begin
      read_word = status_word;
    end
    else
    begin
      // Unmapped
      read_word = '0;
    end
  end

  always_ff @(posedge host_mem_if)
  begin
    if (reset)
    begin
      csr_readdatavalid <= 1'b0;
    end
    else
    begin
      csr_readdatavalid <= csr_read;
    end
  end

  always_ff @(posedge host_mem_if)
  begin
    if (csr_read)
    begin
      csr_readdata <= read_word;
    end
  end

endmodule

`default_nettype wire

/* wr_burst_tracker.sv */
// Host write burst tracking of remaining beats, start of burst and
// a saturating open-burst cycle counter
`default_nettype none

module wr_burst_tracker
  import mem_mon_pkg::*;
(
  input  wire logic                   host_mem_if,
  input  wire logic                   reset,
  input  wire logic                   host_beat,
  input  wire logic [burst_width-1:0] host_beat_burst,
  output logic                        sop,
  output logic      [burst_width-1:0] bursts_rem,
  output logic      [open_width-1:0]  open_cycles
);

  // Next beat starts a new burst when nothing is outstanding
  assign sop = (bursts_rem == '0);

  always_ff @(posedge host_mem_if)
  begin
    if (reset)
    begin
      bursts_rem <= '0;
    end
    else if (host_beat)
    begin
      if (sop)
      begin
        bursts_rem <= host_beat_burst - 1'b1;
      end
      else
      begin
        bursts_rem <= bursts_rem - 1'b1;
      end
    end
  end

  // Grows while a burst is open so that a hung burst shows up in status
  always_ff @(posedge host_mem_if)
  begin
    if (reset)
    begin
      open_cycles <= '0;
    end
    else if (sop)
    begin
      open_cycles <= '0;
    end
    else if (open_cycles != '1)
    begin
      open_cycles <= open_cycles + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* traffic_counters.sv */
// Per-channel read, read-line, read-response and write counters
// with a synchronous clear
`default_nettype none

module traffic_counters
  import mem_mon_pkg::*;
(
  input  wire logic                                 host_mem_if,
  input  wire logic                                 reset,
  input  wire logic                                 clear,
  input  wire logic [num_channels-1:0]              rd_accept,
  input  wire logic [num_channels*burst_width-1:0]  rd_lines,
  input  wire logic [num_channels-1:0]              wr_accept,
  input  wire logic [num_channels-1:0]              rdresp,
  output logic      [num_counters*count_width-1:0]  count_flat
);

  logic [count_width-1:0] cnt_q [num_counters];

  // Flat position of one counter in channel major order
  function automatic int cnt_idx(input int ch, input counter_kind_e kind);
    return ch * num_kinds + int'(kind);
  endfunction

  always_ff @(posedge host_mem_if)
  begin
    if (reset || clear)
    begin
      for (int i = 0; i < num_counters; i++)
      begin
        cnt_q[i] <= '0;
      end
    end
    else
    begin
      for (int ch = 0; ch < num_channels; ch++)
      begin
        if (rd_accept[ch])
        begin
          cnt_q[cnt_idx(ch, cnt_rd)] <= cnt_q[cnt_idx(ch, cnt_rd)] + 1'b1;
          // Lines requested is the sum of accepted burst counts
          cnt_q[cnt_idx(ch, cnt_rdline)] <= cnt_q[cnt_idx(ch, cnt_rdline)]
            + count_width'(rd_lines[ch*burst_width +: burst_width]);
        end

        if (rdresp[ch])
        begin
          cnt_q[cnt_idx(ch, cnt_rdresp)] <= cnt_q[cnt_idx(ch, cnt_rdresp)] + 1'b1;
        end

        if (wr_accept[ch])
        begin
          cnt_q[cnt_idx(ch, cnt_wr)] <= cnt_q[cnt_idx(ch, cnt_wr)] + 1'b1;
        end
      end
    end
  end

  // Pack for the readout mux
  always_comb
  begin
    for (int i = 0; i < num_counters; i++)
    begin
      count_flat[i*count_width +: count_width] = cnt_q[i];
    end
  end

endmodule

`default_nettype wire

/* avmm_event_capture.sv */
// Registered command, response and write-beat events of the monitored
// channels and the host write port
`default_nettype none

module avmm_event_capture
  import mem_mon_pkg::*;
(
  input  wire logic                                 host_mem_if,
  input  wire logic                                 reset,
  input  wire logic [num_channels-1:0]              mon_read,
  input  wire logic [num_channels-1:0]              mon_write,
  input  wire logic [num_channels-1:0]              mon_waitrequest,
  input  wire logic [num_channels-1:0]              mon_readdatavalid,
  input  wire logic [num_channels*burst_width-1:0]  mon_burstcount,
  input  wire logic                                 host_wr_write,
  input  wire logic                                 host_wr_waitrequest,
  input  wire logic [burst_width-1:0]               host_wr_burstcount,
  output logic      [num_channels-1:0]              rd_accept,
  output logic      [num_channels*burst_width-1:0]  rd_lines,
  output logic      [num_channels-1:0]              wr_accept,
  output logic      [num_channels-1:0]              rdresp,
  output logic                                      host_beat,
  output logic      [burst_width-1:0]               host_beat_burst
);

  logic [num_channels-1:0]             rd_take;
  logic [num_channels-1:0]             wr_take;
  logic [num_channels*burst_width-1:0] lines_take;
  logic                                host_take;

  // Acceptance is command high with no stall
  assign rd_take   = mon_read & ~mon_waitrequest;
  assign wr_take   = mon_write & ~mon_waitrequest;
  assign host_take = host_wr_write & ~host_wr_waitrequest;

  // Burst count only where a read was accepted
  always_comb
  begin
    for (int ch = 0; ch < num_channels; ch++)
    begin
      lines_take[ch*burst_width +: burst_width] =
        rd_take[ch] ? mon_burstcount[ch*burst_width +: burst_width] : '0;
    end
  end

  always_ff @(posedge host_mem_if)
  begin
    if (reset)
    begin
      rd_accept <= '0;
      rd_lines  <= '0;
      wr_accept <= '0;
      rdresp    <= '0;
      host_beat <= 1'b0;
    end
    else
    begin
      rd_accept <= rd_take;
      rd_lines  <= lines_take;
      wr_accept <= wr_take;
      rdresp    <= mon_readdatavalid;
      host_beat <= host_take;
    end
  end

  // Burst count that goes with host_beat
  always_ff @(posedge host_mem_if)
  begin
    host_beat_burst <= host_wr_burstcount;
  end

endmodule

`default_nettype wire

/* mem_mon_pkg.sv */
// Shared widths, counts and register map of the memory traffic monitor
// Counter-kind and register-address enums
`default_nettype none

package mem_mon_pkg;

  // Monitored channels and bus widths
  localparam int num_channels   = 4;
  localparam int burst_width    = 6;
  localparam int count_width    = 32;
  localparam int open_width     = 14;

  // One counter per kind in each channel
  localparam int kind_width     = 2;
  localparam int num_kinds      = 4;
  localparam int num_counters   = num_channels * num_kinds;

  // Register port
  localparam int csr_addr_width = 8;
  localparam int csr_data_width = 64;

  // Low address bits that pick a counter inside the counter window
  localparam int count_sel_width = 4;

  // Field positions in the burst status word
  localparam int status_rem_lsb  = 16;
  localparam int status_sop_bit  = 32;

  typedef enum logic [kind_width-1:0] {
    cnt_rd     = 2'd0,
    cnt_rdline = 2'd1,
    cnt_rdresp = 2'd2,
    cnt_wr     = 2'd3
  } counter_kind_e;

  // Counter window spans reg_count_base up to 15
  typedef enum logic [csr_addr_width-1:0] {
    reg_count_base   = 8'd0,
    reg_burst_status = 8'd16,
    reg_clear        = 8'd32
  } csr_reg_e;

endpackage

`default_nettype wire
